// File: Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert
TOP    = tb_via
FLIST  = compile.f
OBJDIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# pass only if the simulation printed the pass line
run: build
	out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

// File: compile.f
hdl/via_pkg.sv
hdl/via_bus_regs.sv
hdl/via_port_ctrl.sv
hdl/via_timers.sv
hdl/via_irq_ctrl.sv
hdl/via_top.sv
testbench/tb_via.sv

// File: hdl/via_bus_regs.sv
`timescale 1ns/1ns

module via_bus_regs (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              cs_i,
	input  logic              cyc_i,
	input  logic              stb_i,
	input  logic              we_i,
	input  via_pkg::addr_t    adr_i,
	input  via_pkg::byte_t    dat_i,
	input  via_pkg::byte_t    pa_rd_i,
	input  via_pkg::byte_t    pb_rd_i,
	input  via_pkg::count_t   t1_cnt_i,
	input  via_pkg::count_t   t1_latch_i,
	input  via_pkg::count_t   t2_cnt_i,
	input  via_pkg::byte_t    ifr_i,
	output logic              ack_o,
	output via_pkg::byte_t    dat_o,
	output via_pkg::byte_t    ora_o,
	output via_pkg::byte_t    orb_wr_o,
	output logic              orb_we_o,
	output via_pkg::byte_t    ddra_o,
	output via_pkg::byte_t    ddrb_o,
	output logic              pcr_ca1_edge_o,
	output logic              pcr_cb1_edge_o,
	output via_pkg::byte_t    ier_o,
	output via_pkg::byte_t    clr_o,
	output logic              t1_lo_wr_o,
	output logic              t1_hi_wr_o,
	output logic              t2_lo_wr_o,
	output logic              t2_hi_wr_o,
	output via_pkg::byte_t    wdata_o,
	output via_pkg::t1_mode_e t1_mode_o,
	output logic              t2_mode_o
);

	logic sel;    // cycle addressed to us
	logic first;  // the one edge where the access acts
	logic wr;
	via_pkg::byte_t acr_r, pcr_r, ier_r;
	via_pkg::byte_t rd_mux;

	assign sel   = cs_i & cyc_i & stb_i;
	assign first = sel & ~ack_o;  // ack still low
	assign wr    = first & we_i;

	// ============================================================
	// acknowledge, one clock after the access edge
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= sel;  // held while the master keeps stb
		end
	end

	// control and output registers
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ora_o  <= '0;
			ddra_o <= '0;  // all inputs
			ddrb_o <= '0;
			acr_r  <= '0;
			pcr_r  <= '0;
			ier_r  <= '0;
		end else if (wr) begin
			case (adr_i)
				via_pkg::ADR_PA, via_pkg::ADR_ORA: ora_o <= dat_i;
				via_pkg::ADR_DDRA: ddra_o <= dat_i;
				via_pkg::ADR_DDRB: ddrb_o <= dat_i;
				via_pkg::ADR_ACR: acr_r <= dat_i;  // bits 1:0 stored only
				via_pkg::ADR_PCR: pcr_r <= dat_i;
				via_pkg::ADR_IER: begin
					// bit 7 picks set or clear for the ones written
					if (dat_i[via_pkg::IRQ_ANY])
						ier_r <= ier_r | {1'b0, dat_i[6:0]};
					else
						ier_r <= ier_r & ~{1'b0, dat_i[6:0]};
				end
				default: ;  // timers and orb handled elsewhere
			endcase
		end
	end

	assign ier_o          = ier_r;
	assign pcr_ca1_edge_o = pcr_r[via_pkg::PCR_CA1_EDGE];
	assign pcr_cb1_edge_o = pcr_r[via_pkg::PCR_CB1_EDGE];
	assign t1_mode_o      = via_pkg::t1_mode_e'(acr_r[via_pkg::ACR_T1_MODE_LSB +: 2]);
	assign t2_mode_o      = acr_r[via_pkg::ACR_T2_MODE];

	// strobes to the timer block, same edge as the bus write
	assign wdata_o    = dat_i;
	assign orb_wr_o   = dat_i;
	assign orb_we_o   = wr & (adr_i == via_pkg::ADR_PB);
	assign t1_lo_wr_o = wr & ((adr_i == via_pkg::ADR_T1CL) || (adr_i == via_pkg::ADR_T1LL));
	assign t1_hi_wr_o = wr & (adr_i == via_pkg::ADR_T1CH);
	assign t2_lo_wr_o = wr & (adr_i == via_pkg::ADR_T2CL);
	assign t2_hi_wr_o = wr & (adr_i == via_pkg::ADR_T2CH);
	// T1LH only reads back, the latch high byte comes in with T1CH

	// ============================================================
	// read path
	// ============================================================

	always_comb begin
		case (adr_i)
			via_pkg::ADR_PB:   rd_mux = pb_rd_i;
			via_pkg::ADR_PA:   rd_mux = pa_rd_i;
			via_pkg::ADR_DDRB: rd_mux = ddrb_o;
			via_pkg::ADR_DDRA: rd_mux = ddra_o;
			via_pkg::ADR_T1CL: rd_mux = t1_cnt_i[7:0];
			via_pkg::ADR_T1CH: rd_mux = t1_cnt_i[15:8];
			via_pkg::ADR_T1LL: rd_mux = t1_latch_i[7:0];
			via_pkg::ADR_T1LH: rd_mux = t1_latch_i[15:8];
			via_pkg::ADR_T2CL: rd_mux = t2_cnt_i[7:0];
			via_pkg::ADR_T2CH: rd_mux = t2_cnt_i[15:8];
			via_pkg::ADR_ACR:  rd_mux = acr_r;
			via_pkg::ADR_PCR:  rd_mux = pcr_r;
			via_pkg::ADR_IFR:  rd_mux = ifr_i;
			via_pkg::ADR_IER: begin
				rd_mux = ier_r;
				rd_mux[via_pkg::IRQ_ANY] = 1'b1;  // always reads as one
			end
			via_pkg::ADR_ORA:  rd_mux = pa_rd_i;
			default:           rd_mux = '0;  // unused address
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (first)
			dat_o <= rd_mux;  // held through the ack
	end

	// flag clears, one pulse on the access edge
	always_comb begin
		clr_o = '0;
		if (first) begin
			case (adr_i)
				via_pkg::ADR_PA:   clr_o[via_pkg::IRQ_CA1] = 1'b1;  // read or write
				via_pkg::ADR_PB:   clr_o[via_pkg::IRQ_CB1] = 1'b1;
				via_pkg::ADR_T1CL: clr_o[via_pkg::IRQ_T1] = ~we_i;
				via_pkg::ADR_T1CH: clr_o[via_pkg::IRQ_T1] = we_i;
				via_pkg::ADR_T2CL: clr_o[via_pkg::IRQ_T2] = ~we_i;
				via_pkg::ADR_T2CH: clr_o[via_pkg::IRQ_T2] = we_i;
				via_pkg::ADR_IFR:  if (we_i) clr_o = dat_i;  // write one to clear
				default: ;
			endcase
		end
	end

	// an ack must follow an access edge, never appear on its own
	ack_after_sel: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(ack_o) |-> $past(first));

endmodule

// File: hdl/via_irq_ctrl.sv
`timescale 1ns/1ns

module via_irq_ctrl (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           ca1_ev_i,
	input  logic           cb1_ev_i,
	input  logic           t1_zero_i,
	input  logic           t2_zero_i,
	input  via_pkg::byte_t ier_i,
	input  via_pkg::byte_t clr_i,
	output via_pkg::byte_t ifr_o,
	output logic           irq_o
);

	via_pkg::byte_t ev_vec;  // events placed at their IFR bits
	via_pkg::byte_t flag_r;

	always_comb begin
		ev_vec = '0;
		ev_vec[via_pkg::IRQ_CA1] = ca1_ev_i;
		ev_vec[via_pkg::IRQ_CB1] = cb1_ev_i;
		ev_vec[via_pkg::IRQ_T1]  = t1_zero_i;
		ev_vec[via_pkg::IRQ_T2]  = t2_zero_i;
	end

	// ============================================================
	// flags and interrupt line
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			flag_r <= '0;
			irq_o  <= 1'b0;
		end else begin
			flag_r <= ev_vec | (flag_r & ~clr_i);  // set beats clear
			irq_o  <= |(flag_r & ier_i);           // one clock behind the flag
		end
	end

	always_comb begin
		ifr_o = flag_r;
		ifr_o[via_pkg::IRQ_ANY] = irq_o;
	end

	// irq only ever follows an enabled flag
	irq_has_source: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_o |-> $past(|(flag_r & ier_i)));

endmodule

// File: hdl/via_pkg.sv
package via_pkg;

	// ============================================================
	// widths
	// ============================================================

	typedef logic [7:0]  byte_t;   // bus and port byte
	typedef logic [3:0]  addr_t;   // register select
	typedef logic [15:0] count_t;  // timer counter / latch

	// timer 1 modes, ACR bits 7:6
	typedef enum logic [1:0] {
		T1_ONESHOT     = 2'd0,
		T1_FREERUN     = 2'd1,
		T1_ONESHOT_PB7 = 2'd2,  // pb7 goes high on zero
		T1_FREERUN_PB7 = 2'd3   // pb7 toggles on every zero
	} t1_mode_e;

	// ============================================================
	// register map
	// ============================================================

	localparam addr_t ADR_PB   = 4'd0;
	localparam addr_t ADR_PA   = 4'd1;
	localparam addr_t ADR_DDRB = 4'd2;
	localparam addr_t ADR_DDRA = 4'd3;
	localparam addr_t ADR_T1CL = 4'd4;
	localparam addr_t ADR_T1CH = 4'd5;
	localparam addr_t ADR_T1LL = 4'd6;
	localparam addr_t ADR_T1LH = 4'd7;
	localparam addr_t ADR_T2CL = 4'd8;
	localparam addr_t ADR_T2CH = 4'd9;
	// 10 is a hole, reads zero
	localparam addr_t ADR_ACR  = 4'd11;
	localparam addr_t ADR_PCR  = 4'd12;
	localparam addr_t ADR_IFR  = 4'd13;
	localparam addr_t ADR_IER  = 4'd14;
	localparam addr_t ADR_ORA  = 4'd15;

	// IFR / IER bit positions
	localparam int IRQ_CA1 = 1;
	localparam int IRQ_CB1 = 4;
	localparam int IRQ_T1  = 5;
	localparam int IRQ_T2  = 6;
	localparam int IRQ_ANY = 7;  // irq in IFR, set/clear select in IER writes

	// ACR / PCR fields
	localparam int ACR_T2_MODE     = 5;  // 1 = count pb6 falling edges
	localparam int ACR_T1_MODE_LSB = 6;
	localparam int PCR_CA1_EDGE    = 0;  // 1 = rising edge active
	localparam int PCR_CB1_EDGE    = 4;

	localparam count_t COUNT_RESET = 16'hFFFF;  // both timers after reset

endpackage

// File: hdl/via_port_ctrl.sv
`timescale 1ns/1ns

module via_port_ctrl (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           ca1_i,
	input  logic           cb1_i,
	input  via_pkg::byte_t pa_i,
	input  via_pkg::byte_t pb_i,
	input  via_pkg::byte_t ddrb_i,
	input  via_pkg::byte_t orb_i,
	input  logic           ca1_edge_i,
	input  logic           cb1_edge_i,
	output via_pkg::byte_t pa_rd_o,
	output via_pkg::byte_t pb_rd_o,
	output logic           ca1_ev_o,
	output logic           cb1_ev_o,
	output logic           pb6_fall_o
);

	logic [1:0] ca1_sync, cb1_sync;  // [1] is the safe copy
	via_pkg::byte_t pa_s1, pa_s2;
	via_pkg::byte_t pb_s1, pb_s2;
	logic ca1_d, cb1_d, pb6_d;       // previous sampled level

	// ============================================================
	// synchronisers and edge history
	// ============================================================

	// pins flush through during reset, so no false edge afterwards
	always_ff @(posedge clk_i) begin
		ca1_sync <= {ca1_sync[0], ca1_i};
		cb1_sync <= {cb1_sync[0], cb1_i};
		pa_s1    <= pa_i;
		pa_s2    <= pa_s1;
		pb_s1    <= pb_i;
		pb_s2    <= pb_s1;
		ca1_d    <= ca1_sync[1];
		cb1_d    <= cb1_sync[1];
		pb6_d    <= pb_s2[6];
	end

	// active edge pulses
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ca1_ev_o   <= 1'b0;
			cb1_ev_o   <= 1'b0;
			pb6_fall_o <= 1'b0;
		end else begin
			// pcr bit 1 = rising, 0 = falling
			ca1_ev_o <= ca1_edge_i ? (ca1_sync[1] & ~ca1_d)
			                       : (~ca1_sync[1] & ca1_d);
			cb1_ev_o <= cb1_edge_i ? (cb1_sync[1] & ~cb1_d)
			                       : (~cb1_sync[1] & cb1_d);
			pb6_fall_o <= ~pb_s2[6] & pb6_d;  // timer 2 count source
		end
	end

	// read values
	assign pa_rd_o = pa_s2;
	assign pb_rd_o = (ddrb_i & orb_i) | (~ddrb_i & pb_s2);  // outputs read back orb

endmodule

// File: hdl/via_timers.sv
`timescale 1ns/1ns

module via_timers (
	input  logic              clk_i,
	input  logic              rst_i,
	input  via_pkg::byte_t    wdata_i,
	input  logic              t1_lo_wr_i,
	input  logic              t1_hi_wr_i,
	input  logic              t2_lo_wr_i,
	input  logic              t2_hi_wr_i,
	input  via_pkg::t1_mode_e t1_mode_i,
	input  logic              t2_mode_i,
	input  logic              pb6_fall_i,
	input  logic              orb_we_i,
	input  via_pkg::byte_t    orb_wr_i,
	output via_pkg::count_t   t1_cnt_o,
	output via_pkg::count_t   t1_latch_o,
	output via_pkg::count_t   t2_cnt_o,
	output logic              t1_zero_o,
	output logic              t2_zero_o,
	output via_pkg::byte_t    orb_o
);

	logic t1_freerun;        // reload from latch on zero
	logic t1_pb7;            // pb7 follows timer 1
	logic t1_armed, t2_armed;
	logic t1_fire, t2_fire;  // counter reaches zero this edge
	logic t2_dec;
	via_pkg::count_t t1_next;
	via_pkg::byte_t t2_lo;   // t2 low latch

	assign t1_freerun = (t1_mode_i == via_pkg::T1_FREERUN) ||
	                    (t1_mode_i == via_pkg::T1_FREERUN_PB7);
	assign t1_pb7     = (t1_mode_i == via_pkg::T1_ONESHOT_PB7) ||
	                    (t1_mode_i == via_pkg::T1_FREERUN_PB7);

	// ============================================================
	// timer 1
	// ============================================================

	always_comb begin
		if (t1_hi_wr_i)
			t1_next = {wdata_i, t1_latch_o[7:0]};  // load and start
		else if ((t1_cnt_o == '0) && t1_freerun)
			t1_next = t1_latch_o;
		else
			t1_next = t1_cnt_o - 16'd1;  // one-shot wraps past zero
	end

	assign t1_fire = t1_armed & ~t1_hi_wr_i & (t1_next == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			t1_cnt_o   <= via_pkg::COUNT_RESET;
			t1_latch_o <= via_pkg::COUNT_RESET;
			t1_armed   <= 1'b0;
			t1_zero_o  <= 1'b0;
		end else begin
			t1_cnt_o  <= t1_next;
			t1_zero_o <= t1_fire;
			if (t1_lo_wr_i)
				t1_latch_o[7:0] <= wdata_i;
			if (t1_hi_wr_i) begin
				t1_latch_o[15:8] <= wdata_i;
				t1_armed <= 1'b1;
			end else if (t1_fire && !t1_freerun) begin
				t1_armed <= 1'b0;  // one flag per load
			end
		end
	end

	// ============================================================
	// timer 2
	// ============================================================

	assign t2_dec  = ~t2_mode_i | pb6_fall_i;  // clock or pb6 falling edge
	assign t2_fire = t2_armed & ~t2_hi_wr_i & t2_dec & (t2_cnt_o == 16'd1);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			t2_cnt_o  <= via_pkg::COUNT_RESET;
			t2_lo     <= via_pkg::COUNT_RESET[7:0];
			t2_armed  <= 1'b0;
			t2_zero_o <= 1'b0;
		end else begin
			t2_zero_o <= t2_fire;
			if (t2_lo_wr_i)
				t2_lo <= wdata_i;
			if (t2_hi_wr_i) begin
				t2_cnt_o <= {wdata_i, t2_lo};
				t2_armed <= 1'b1;
			end else begin
				if (t2_dec)
					t2_cnt_o <= t2_cnt_o - 16'd1;  // keeps going after zero
				if (t2_fire)
					t2_armed <= 1'b0;
			end
		end
	end

	// port B output register, bit 7 shared with timer 1
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			orb_o <= '0;
		end else begin
			if (orb_we_i)
				orb_o <= orb_wr_i;
			if (t1_hi_wr_i && t1_pb7)
				orb_o[7] <= 1'b0;  // low while counting
			if (t1_fire && t1_pb7)
				orb_o[7] <= t1_freerun ? ~orb_o[7] : 1'b1;
		end
	end

	// pb7 moves only by a bus write or by timer 1 in a pb7 mode
	orb7_source: assert property (@(posedge clk_i) disable iff (rst_i)
		$changed(orb_o[7]) |-> $past(orb_we_i || (t1_pb7 && (t1_hi_wr_i || t1_fire))));

endmodule

// File: hdl/via_top.sv
`timescale 1ns/1ns

module via_top (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           cs_i,
	input  logic           cyc_i,
	input  logic           stb_i,
	input  logic           we_i,
	input  via_pkg::addr_t adr_i,
	input  via_pkg::byte_t dat_i,
	output logic           ack_o,
	output via_pkg::byte_t dat_o,
	output logic           irq_o,
	input  logic           ca1_i,
	input  logic           cb1_i,
	input  via_pkg::byte_t pa_i,
	input  via_pkg::byte_t pb_i,
	output via_pkg::byte_t pa_o,
	output via_pkg::byte_t pb_o,
	output via_pkg::byte_t pa_t_o,
	output via_pkg::byte_t pb_t_o
);

	via_pkg::byte_t    ora, orb, orb_wr, ddra, ddrb;
	via_pkg::byte_t    pa_rd, pb_rd, ifr, ier, clr, wdata;
	via_pkg::count_t   t1_cnt, t1_latch, t2_cnt;
	via_pkg::t1_mode_e t1_mode;
	logic t2_mode, orb_we;
	logic ca1_edge, cb1_edge;
	logic ca1_ev, cb1_ev, pb6_fall;
	logic t1_zero, t2_zero;
	logic t1_lo_wr, t1_hi_wr, t2_lo_wr, t2_hi_wr;

	// bus side
	via_bus_regs i_bus_regs (
		.clk_i(clk_i), .rst_i(rst_i),
		.cs_i(cs_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
		.adr_i(adr_i), .dat_i(dat_i),
		.pa_rd_i(pa_rd), .pb_rd_i(pb_rd),
		.t1_cnt_i(t1_cnt), .t1_latch_i(t1_latch), .t2_cnt_i(t2_cnt),
		.ifr_i(ifr),
		.ack_o(ack_o), .dat_o(dat_o),
		.ora_o(ora), .orb_wr_o(orb_wr), .orb_we_o(orb_we),
		.ddra_o(ddra), .ddrb_o(ddrb),
		.pcr_ca1_edge_o(ca1_edge), .pcr_cb1_edge_o(cb1_edge),
		.ier_o(ier), .clr_o(clr),
		.t1_lo_wr_o(t1_lo_wr), .t1_hi_wr_o(t1_hi_wr),
		.t2_lo_wr_o(t2_lo_wr), .t2_hi_wr_o(t2_hi_wr),
		.wdata_o(wdata), .t1_mode_o(t1_mode), .t2_mode_o(t2_mode)
	);

	via_port_ctrl i_port_ctrl (
		.clk_i(clk_i), .rst_i(rst_i),
		.ca1_i(ca1_i), .cb1_i(cb1_i), .pa_i(pa_i), .pb_i(pb_i),
		.ddrb_i(ddrb), .orb_i(orb),
		.ca1_edge_i(ca1_edge), .cb1_edge_i(cb1_edge),
		.pa_rd_o(pa_rd), .pb_rd_o(pb_rd),
		.ca1_ev_o(ca1_ev), .cb1_ev_o(cb1_ev), .pb6_fall_o(pb6_fall)
	);

	via_timers i_timers (
		.clk_i(clk_i), .rst_i(rst_i), .wdata_i(wdata),
		.t1_lo_wr_i(t1_lo_wr), .t1_hi_wr_i(t1_hi_wr),
		.t2_lo_wr_i(t2_lo_wr), .t2_hi_wr_i(t2_hi_wr),
		.t1_mode_i(t1_mode), .t2_mode_i(t2_mode), .pb6_fall_i(pb6_fall),
		.orb_we_i(orb_we), .orb_wr_i(orb_wr),
		.t1_cnt_o(t1_cnt), .t1_latch_o(t1_latch), .t2_cnt_o(t2_cnt),
		.t1_zero_o(t1_zero), .t2_zero_o(t2_zero), .orb_o(orb)
	);

	via_irq_ctrl i_irq_ctrl (
		.clk_i(clk_i), .rst_i(rst_i),
		.ca1_ev_i(ca1_ev), .cb1_ev_i(cb1_ev),
		.t1_zero_i(t1_zero), .t2_zero_i(t2_zero),
		.ier_i(ier), .clr_i(clr),
		.ifr_o(ifr), .irq_o(irq_o)
	);

	// pins, direction bit 1 = output
	assign pa_o   = ora;
	assign pb_o   = orb;
	assign pa_t_o = ddra;
	assign pb_t_o = ddrb;

endmodule

// File: testbench/tb_via.sv
`timescale 1ns/1ns

module tb_via;

	// table operations
	typedef enum logic [2:0] {
		OP_WR,    // bus write
		OP_RD,    // bus read, dat is the compare mask, zero only reads
		OP_PINS,  // drive a pin group
		OP_OUT,   // check a pin output, dat is the mask
		OP_IRQ,   // wait for irq_o, dat is the limit in cycles
		OP_IDLE   // dat clocks of nothing
	} op_e;

	// pin groups for OP_PINS and OP_OUT
	typedef enum logic [3:0] {
		SEL_PA, SEL_PB, SEL_CA1, SEL_CB1,
		SEL_PA_O, SEL_PA_T, SEL_PB_O, SEL_PB_T, SEL_IRQ
	} sel_e;

	typedef struct packed {
		op_e            op;
		logic [3:0]     adr;   // register address or pin group
		via_pkg::byte_t dat;
		via_pkg::byte_t want;  // expected value after masking
	} step_t;

	logic           clk_i, rst_i;
	logic           cs_i, cyc_i, stb_i, we_i;
	via_pkg::addr_t adr_i;
	via_pkg::byte_t dat_i, dat_o;
	logic           ack_o, irq_o;
	logic           ca1_i, cb1_i;
	via_pkg::byte_t pa_i, pb_i, pa_o, pb_o, pa_t_o, pb_t_o;

	step_t  steps[$];
	int     errors;
	int     timeouts;
	integer seed;

	via_top i_dut (
		.clk_i(clk_i), .rst_i(rst_i),
		.cs_i(cs_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
		.adr_i(adr_i), .dat_i(dat_i), .ack_o(ack_o), .dat_o(dat_o),
		.irq_o(irq_o), .ca1_i(ca1_i), .cb1_i(cb1_i),
		.pa_i(pa_i), .pb_i(pb_i), .pa_o(pa_o), .pb_o(pb_o),
		.pa_t_o(pa_t_o), .pb_t_o(pb_t_o)
	);

	always #2 clk_i = ~clk_i;  // 4 ns period

	// ============================================================
	// helpers
	// ============================================================

	task automatic finish_run();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	endtask

	task automatic check(string name, via_pkg::byte_t act, via_pkg::byte_t want);
		if (act !== want) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, act, want);
			errors++;
		end
	endtask

	function automatic via_pkg::byte_t rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic void add_step(op_e op, logic [3:0] adr, via_pkg::byte_t dat,
	                                 via_pkg::byte_t want);
		step_t s;
		s.op   = op;
		s.adr  = adr;
		s.dat  = dat;
		s.want = want;
		steps.push_back(s);
	endfunction

	// called on a falling edge, ack seen on a later falling edge
	task automatic wait_ack(via_pkg::addr_t adr);
		int n;
		n = 0;
		while (ack_o !== 1'b1 && n < 16) begin
			@(negedge clk_i);
			n++;
		end
		if (ack_o !== 1'b1) begin
			$display("no bus acknowledge from address 0x%h after %0d cycles", adr, n);
			timeouts++;
		end
	endtask

	task automatic bus_write(via_pkg::addr_t adr, via_pkg::byte_t dat);
		@(negedge clk_i);  // one idle edge lets ack drop first
		cs_i  = 1'b1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = 1'b1;
		adr_i = adr;
		dat_i = dat;
		wait_ack(adr);
		cs_i  = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	task automatic bus_read(via_pkg::addr_t adr, output via_pkg::byte_t data);
		@(negedge clk_i);
		cs_i  = 1'b1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = 1'b0;
		adr_i = adr;
		wait_ack(adr);
		data  = dat_o;  // registered, stable during ack
		cs_i  = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
	endtask

	task automatic wait_irq(int limit);
		int n;
		n = 0;
		while (irq_o !== 1'b1 && n < limit) begin
			@(negedge clk_i);
			n++;
		end
		if (irq_o !== 1'b1) begin
			$display("irq_o stayed low for %0d cycles", limit);
			timeouts++;
		end
	endtask

	task automatic apply_step(step_t s, int idx);
		via_pkg::byte_t rd;
		via_pkg::byte_t val;
		string          nm;
		case (s.op)
			OP_WR: bus_write(s.adr, s.dat);
			OP_RD: begin
				bus_read(s.adr, rd);
				if (s.dat != 8'h00)
					check($sformatf("dat_o at address 0x%h, step %0d", s.adr, idx),
					      rd & s.dat, s.want);
			end
			OP_PINS: begin
				@(negedge clk_i);
				case (s.adr)
					SEL_PA:  pa_i = s.dat;
					SEL_PB:  pb_i = s.dat;
					SEL_CA1: ca1_i = s.dat[0];
					default: cb1_i = s.dat[0];
				endcase
			end
			OP_OUT: begin
				case (s.adr)
					SEL_PA_O: begin nm = "pa_o"; val = pa_o; end
					SEL_PA_T: begin nm = "pa_t_o"; val = pa_t_o; end
					SEL_PB_O: begin nm = "pb_o"; val = pb_o; end
					SEL_PB_T: begin nm = "pb_t_o"; val = pb_t_o; end
					default:  begin nm = "irq_o"; val = {7'b0, irq_o}; end
				endcase
				check($sformatf("%s, step %0d", nm, idx), val & s.dat, s.want);
			end
			OP_IRQ: wait_irq(int'(s.dat));
			default: repeat (s.dat) @(negedge clk_i);
		endcase
	endtask

	// ============================================================
	// stimulus table
	// ============================================================

	function automatic void build_table();
		via_pkg::byte_t ddra_v, ora_v, ddrb_v, orb_v, pa_v, pb_v;
		via_pkg::byte_t pb_rd_v;  // port B as read back
		ddra_v = rand_byte();
		ora_v  = rand_byte();
		ddrb_v = rand_byte();
		orb_v  = rand_byte();
		pa_v   = rand_byte();
		pb_v   = rand_byte();
		// output bits give orb, input bits give the pin
		for (int b = 0; b < 8; b++)
			pb_rd_v[b] = ddrb_v[b] ? orb_v[b] : pb_v[b];

		// ports and direction
		add_step(OP_WR, via_pkg::ADR_DDRA, ddra_v, 8'h00);
		add_step(OP_WR, via_pkg::ADR_ORA, ora_v, 8'h00);
		add_step(OP_WR, via_pkg::ADR_DDRB, ddrb_v, 8'h00);
		add_step(OP_WR, via_pkg::ADR_PB, orb_v, 8'h00);   // orb write
		add_step(OP_OUT, SEL_PA_O, 8'hFF, ora_v);
		add_step(OP_OUT, SEL_PA_T, 8'hFF, ddra_v);
		add_step(OP_OUT, SEL_PB_O, 8'hFF, orb_v);
		add_step(OP_OUT, SEL_PB_T, 8'hFF, ddrb_v);
		add_step(OP_PINS, SEL_PA, pa_v, 8'h00);
		add_step(OP_PINS, SEL_PB, pb_v, 8'h00);
		add_step(OP_IDLE, 4'd0, 8'd4, 8'h00);              // through the synchroniser
		add_step(OP_RD, via_pkg::ADR_PB, 8'hFF, pb_rd_v);
		add_step(OP_RD, via_pkg::ADR_PA, 8'hFF, pa_v);

		// ca1 rising, cb1 falling
		add_step(OP_WR, via_pkg::ADR_PCR, 8'h01, 8'h00);
		add_step(OP_WR, via_pkg::ADR_IER, 8'h92, 8'h00);  // set ca1, cb1
		add_step(OP_PINS, SEL_CA1, 8'h01, 8'h00);
		add_step(OP_IRQ, 4'd0, 8'd20, 8'h00);
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h82);
		add_step(OP_RD, via_pkg::ADR_PA, 8'hFF, pa_v);    // clears ca1
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h00);
		add_step(OP_PINS, SEL_CA1, 8'h00, 8'h00);         // falling, ignored
		add_step(OP_IDLE, 4'd0, 8'd8, 8'h00);
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h00);
		add_step(OP_PINS, SEL_CB1, 8'h00, 8'h00);
		add_step(OP_IRQ, 4'd0, 8'd20, 8'h00);
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h90);
		add_step(OP_RD, via_pkg::ADR_PB, 8'hFF, pb_rd_v); // clears cb1
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h00);
		add_step(OP_PINS, SEL_CB1, 8'h01, 8'h00);         // rising, ignored
		add_step(OP_IDLE, 4'd0, 8'd8, 8'h00);
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h00);
		add_step(OP_OUT, SEL_IRQ, 8'h01, 8'h00);

		// timer 1 one-shot, count 0x0010
		add_step(OP_WR, via_pkg::ADR_ACR, 8'h00, 8'h00);
		add_step(OP_WR, via_pkg::ADR_IER, 8'hA0, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T1LL, 8'h10, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T1CH, 8'h00, 8'h00);
		add_step(OP_RD, via_pkg::ADR_T1LL, 8'hFF, 8'h10);
		add_step(OP_RD, via_pkg::ADR_T1LH, 8'hFF, 8'h00);
		add_step(OP_IRQ, 4'd0, 8'd60, 8'h00);
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'hA0);
		add_step(OP_RD, via_pkg::ADR_T1CL, 8'h00, 8'h00); // clears t1
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h00);
		add_step(OP_OUT, SEL_IRQ, 8'h01, 8'h00);
		add_step(OP_IDLE, 4'd0, 8'd40, 8'h00);             // longer than the count
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hFF, 8'h00);

		// timer 1 free-run, pb7 toggles on every zero
		add_step(OP_WR, via_pkg::ADR_ACR, 8'hC0, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T1LL, 8'h20, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T1CH, 8'h00, 8'h00);
		add_step(OP_OUT, SEL_PB_O, 8'h80, 8'h00);          // low while counting
		add_step(OP_IRQ, 4'd0, 8'd80, 8'h00);
		add_step(OP_OUT, SEL_PB_O, 8'h80, 8'h80);
		add_step(OP_WR, via_pkg::ADR_IFR, 8'h20, 8'h00);
		add_step(OP_IDLE, 4'd0, 8'd2, 8'h00);              // irq lags the flag
		add_step(OP_OUT, SEL_IRQ, 8'h01, 8'h00);
		add_step(OP_IRQ, 4'd0, 8'd80, 8'h00);
		add_step(OP_OUT, SEL_PB_O, 8'h80, 8'h00);
		add_step(OP_WR, via_pkg::ADR_IFR, 8'h20, 8'h00);
		add_step(OP_IDLE, 4'd0, 8'd2, 8'h00);
		add_step(OP_IRQ, 4'd0, 8'd80, 8'h00);
		add_step(OP_OUT, SEL_PB_O, 8'h80, 8'h80);

		// timer 2 on pb6 falling edges, t1 back to one-shot
		add_step(OP_PINS, SEL_PB, 8'h40, 8'h00);
		add_step(OP_IDLE, 4'd0, 8'd6, 8'h00);
		add_step(OP_WR, via_pkg::ADR_ACR, 8'h20, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T2CL, 8'h03, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T2CH, 8'h00, 8'h00);
		for (int e = 0; e < 3; e++) begin
			add_step(OP_PINS, SEL_PB, 8'h00, 8'h00);       // falling edge
			add_step(OP_IDLE, 4'd0, 8'd6, 8'h00);
			add_step(OP_PINS, SEL_PB, 8'h40, 8'h00);
			add_step(OP_IDLE, 4'd0, 8'd6, 8'h00);
			if (e == 1) begin
				add_step(OP_RD, via_pkg::ADR_IFR, 8'h40, 8'h00);
				add_step(OP_RD, via_pkg::ADR_T2CL, 8'hFF, 8'h01);
			end
		end
		add_step(OP_RD, via_pkg::ADR_IFR, 8'h40, 8'h40);
		add_step(OP_RD, via_pkg::ADR_T2CL, 8'hFF, 8'h00);

		// ier masking, flag without irq
		add_step(OP_WR, via_pkg::ADR_IER, 8'h7F, 8'h00);  // bit 7 low, clear all
		add_step(OP_WR, via_pkg::ADR_IFR, 8'h7F, 8'h00);
		add_step(OP_WR, via_pkg::ADR_ACR, 8'h00, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T2CL, 8'h08, 8'h00);
		add_step(OP_WR, via_pkg::ADR_T2CH, 8'h00, 8'h00);
		add_step(OP_IDLE, 4'd0, 8'd20, 8'h00);
		add_step(OP_RD, via_pkg::ADR_IFR, 8'hC0, 8'h40);
		add_step(OP_OUT, SEL_IRQ, 8'h01, 8'h00);
		add_step(OP_RD, via_pkg::ADR_IER, 8'hFF, 8'h80);
	endfunction

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		clk_i    = 1'b0;
		rst_i    = 1'b1;
		cs_i     = 1'b0;
		cyc_i    = 1'b0;
		stb_i    = 1'b0;
		we_i     = 1'b0;
		adr_i    = '0;
		dat_i    = '0;
		ca1_i    = 1'b0;
		cb1_i    = 1'b1;  // idle high for the falling edge later
		pa_i     = '0;
		pb_i     = '0;
		errors   = 0;
		timeouts = 0;
		seed     = 86451;
		build_table();
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		// a timeout ends the table early
		for (int i = 0; i < steps.size() && timeouts == 0; i++)
			apply_step(steps[i], i);
		finish_run();
	end

endmodule
